// File: verilog/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// first instruction address after reset (kseg1 boot rom)
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// primary opcodes, instr[31:26]
`define MIPS_OP_RTYPE 6'h00 // funct field selects the operation
`define MIPS_OP_J     6'h02
`define MIPS_OP_JAL   6'h03
`define MIPS_OP_BEQ   6'h04
`define MIPS_OP_BNE   6'h05
`define MIPS_OP_ADDIU 6'h09
`define MIPS_OP_SLTI  6'h0a
`define MIPS_OP_ANDI  6'h0c // zero extended immediate
`define MIPS_OP_ORI   6'h0d // zero extended immediate
`define MIPS_OP_XORI  6'h0e // zero extended immediate
`define MIPS_OP_LUI   6'h0f
`define MIPS_OP_LW    6'h23
`define MIPS_OP_SW    6'h2b

// r-type function codes, instr[5:0]
`define MIPS_FN_SLL  6'h00
`define MIPS_FN_SRL  6'h02
`define MIPS_FN_JR   6'h08
`define MIPS_FN_ADDU 6'h21
`define MIPS_FN_SUBU 6'h23
`define MIPS_FN_AND  6'h24
`define MIPS_FN_OR   6'h25
`define MIPS_FN_XOR  6'h26
`define MIPS_FN_SLT  6'h2a

// architectural register numbers
`define MIPS_REG_V0 5'd2  // result register, exported as register_v0
`define MIPS_REG_RA 5'd31 // link register for jal

`endif

// File: verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;    // data word or byte address
  typedef logic [4:0]  reg_idx_t; // gpr number
  typedef logic [5:0]  opcode_t;  // instr[31:26]
  typedef logic [5:0]  funct_t;   // instr[5:0]
  typedef logic [4:0]  shamt_t;   // instr[10:6]

  // per-instruction sequence, one pass through fetch..exec
  typedef enum logic [2:0] {
    FETCH  = 3'd0, // one idle cycle before the instruction read
    LOAD   = 3'd1, // instruction read, held until waitrequest low
    MEM    = 3'd2, // data access for lw/sw, else a single cycle
    EXEC   = 3'd3, // pc and register file update at the end
    HALTED = 3'd4  // reached after executing at address 0
  } cpu_state_t;

  // operation performed on the operand pair
  typedef enum logic [3:0] {
    ADD = 4'd0, // addu, addiu, lw/sw address
    SUB = 4'd1,
    AND = 4'd2,
    OR  = 4'd3,
    XOR = 4'd4,
    SLT = 4'd5, // signed compare
    SLL = 4'd6, // rt shifted by shamt
    SRL = 4'd7,
    LUI = 4'd8  // immediate into upper half
  } alu_op_t;

endpackage

`default_nettype wire

// File: verilog/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded controls for the instruction held in the instruction register
interface decode_if;
  mips_pkg::reg_idx_t dest_reg;     // rd, rt or ra
  logic               reg_write;    // commit to register file in exec
  mips_pkg::alu_op_t  alu_op;
  logic               alu_src_imm;  // second operand is the immediate
  logic               imm_zero_ext; // logical immediates
  logic               mem_read;     // lw
  logic               mem_write;    // sw
  logic               link;         // write pc+8 back
  logic               branch;       // beq/bne
  logic               branch_ne;    // invert the equality test
  logic               jump;         // j/jal, 26-bit target
  logic               jump_reg;     // jr, target from rs

  modport decoder (
    output dest_reg, reg_write, alu_op, alu_src_imm, imm_zero_ext,
    output mem_read, mem_write, link, branch, branch_ne, jump, jump_reg
  );

  modport datapath (
    input dest_reg, reg_write, alu_op, alu_src_imm, imm_zero_ext,
    input mem_read, mem_write, link, branch, branch_ne, jump, jump_reg
  );
endinterface

`default_nettype wire

// File: verilog/cpu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 waitrequest,
  input  wire mips_pkg::word_t      readdata,
  input  wire mips_pkg::word_t      pc,
  decode_if.datapath                dec,
  output mips_pkg::cpu_state_t      state,
  output mips_pkg::word_t           instr,     // instruction register
  output mips_pkg::word_t           load_data, // lw data register
  output logic                      read,
  output logic                      write,
  output logic                      data_phase, // address comes from the alu
  output logic                      active
);

  logic mem_access; // current instruction touches data memory

  assign mem_access = dec.mem_read | dec.mem_write;

  // strobes follow the state, data strobes only for lw/sw
  assign read       = (state == mips_pkg::LOAD) | ((state == mips_pkg::MEM) & dec.mem_read);
  assign write      = (state == mips_pkg::MEM) & dec.mem_write;
  assign data_phase = (state == mips_pkg::MEM);

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= mips_pkg::FETCH;
      active <= 1'b1;
    end else begin
      case (state)
        mips_pkg::FETCH: state <= mips_pkg::LOAD;
        mips_pkg::LOAD: if (!waitrequest) state <= mips_pkg::MEM; // instruction arrives
        mips_pkg::MEM: begin
          if (!mem_access || !waitrequest) state <= mips_pkg::EXEC;
        end
        mips_pkg::EXEC: begin
          // instruction at address 0 is the last one executed
          if (pc == '0) begin
            state  <= mips_pkg::HALTED;
            active <= 1'b0;
          end else begin
            state <= mips_pkg::FETCH;
          end
        end
        mips_pkg::HALTED: state <= mips_pkg::HALTED; // stays until reset
        default: state <= mips_pkg::HALTED;
      endcase
    end
  end

  // capture bus data in the cycle the access completes
  always_ff @(posedge clk) begin
    if (state == mips_pkg::LOAD && !waitrequest) instr <= readdata;
    if (state == mips_pkg::MEM && dec.mem_read && !waitrequest) load_data <= readdata;
  end

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module instr_decoder (
  input  wire mips_pkg::word_t instr,
  decode_if.decoder            dec
);

  mips_pkg::opcode_t  opcode;
  mips_pkg::funct_t   funct;
  mips_pkg::reg_idx_t rt;
  mips_pkg::reg_idx_t rd;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];

  always_comb begin
    // unknown encodings fall through as a nop
    dec.dest_reg     = rt; // i-type default
    dec.reg_write    = 1'b0;
    dec.alu_op       = mips_pkg::ADD;
    dec.alu_src_imm  = 1'b0;
    dec.imm_zero_ext = 1'b0;
    dec.mem_read     = 1'b0;
    dec.mem_write    = 1'b0;
    dec.link         = 1'b0;
    dec.branch       = 1'b0;
    dec.branch_ne    = 1'b0;
    dec.jump         = 1'b0;
    dec.jump_reg     = 1'b0;

    case (opcode)
      `MIPS_OP_RTYPE: begin
        dec.dest_reg  = rd;
        dec.reg_write = 1'b1;
        case (funct)
          `MIPS_FN_SLL:  dec.alu_op = mips_pkg::SLL;
          `MIPS_FN_SRL:  dec.alu_op = mips_pkg::SRL;
          `MIPS_FN_ADDU: dec.alu_op = mips_pkg::ADD;
          `MIPS_FN_SUBU: dec.alu_op = mips_pkg::SUB;
          `MIPS_FN_AND:  dec.alu_op = mips_pkg::AND;
          `MIPS_FN_OR:   dec.alu_op = mips_pkg::OR;
          `MIPS_FN_XOR:  dec.alu_op = mips_pkg::XOR;
          `MIPS_FN_SLT:  dec.alu_op = mips_pkg::SLT;
          `MIPS_FN_JR: begin
            dec.reg_write = 1'b0; // no link for plain jr
            dec.jump_reg  = 1'b1;
          end
          default: dec.reg_write = 1'b0;
        endcase
      end
      `MIPS_OP_J: dec.jump = 1'b1;
      `MIPS_OP_JAL: begin
        dec.jump      = 1'b1;
        dec.link      = 1'b1;
        dec.reg_write = 1'b1;
        dec.dest_reg  = `MIPS_REG_RA;
      end
      `MIPS_OP_BEQ: dec.branch = 1'b1;
      `MIPS_OP_BNE: begin
        dec.branch    = 1'b1;
        dec.branch_ne = 1'b1;
      end
      `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_LUI: begin
        dec.reg_write   = 1'b1;
        dec.alu_src_imm = 1'b1; // sign extended
        if (opcode == `MIPS_OP_SLTI) dec.alu_op = mips_pkg::SLT;
        if (opcode == `MIPS_OP_LUI)  dec.alu_op = mips_pkg::LUI;
      end
      `MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI: begin
        dec.reg_write    = 1'b1;
        dec.alu_src_imm  = 1'b1;
        dec.imm_zero_ext = 1'b1;
        case (opcode)
          `MIPS_OP_ANDI: dec.alu_op = mips_pkg::AND;
          `MIPS_OP_ORI:  dec.alu_op = mips_pkg::OR;
          default:       dec.alu_op = mips_pkg::XOR;
        endcase
      end
      `MIPS_OP_LW: begin
        dec.reg_write   = 1'b1;
        dec.alu_src_imm = 1'b1; // base + offset
        dec.mem_read    = 1'b1;
      end
      `MIPS_OP_SW: begin
        dec.alu_src_imm = 1'b1;
        dec.mem_write   = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module register_file (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               exec,     // commit cycle
  input  wire mips_pkg::reg_idx_t rs_idx,
  input  wire mips_pkg::reg_idx_t rt_idx,
  input  wire mips_pkg::reg_idx_t dest_idx,
  input  wire logic               write_en,
  input  wire mips_pkg::word_t    write_data,
  output mips_pkg::word_t         rs_data,
  output mips_pkg::word_t         rt_data,
  output mips_pkg::word_t         register_v0
);

  mips_pkg::word_t regs [32];

  // asynchronous read ports, valid throughout mem and exec
  assign rs_data     = regs[rs_idx];
  assign rt_data     = regs[rt_idx];
  assign register_v0 = regs[`MIPS_REG_V0];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (exec && write_en && dest_idx != '0) begin
      regs[dest_idx] <= write_data; // $zero never written so it reads 0
    end
  end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  decode_if.datapath            dec,
  input  wire mips_pkg::word_t  rs_data,
  input  wire mips_pkg::word_t  rt_data,
  input  wire logic [15:0]      imm,
  input  wire mips_pkg::shamt_t shamt,
  output mips_pkg::word_t       result
);

  mips_pkg::word_t imm_ext;
  mips_pkg::word_t op_b;

  // andi/ori/xori take a zero extended immediate, all others sign extend
  assign imm_ext = dec.imm_zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
  assign op_b    = dec.alu_src_imm ? imm_ext : rt_data;

  always_comb begin
    case (dec.alu_op)
      mips_pkg::ADD: result = rs_data + op_b;
      mips_pkg::SUB: result = rs_data - op_b;
      mips_pkg::AND: result = rs_data & op_b;
      mips_pkg::OR:  result = rs_data | op_b;
      mips_pkg::XOR: result = rs_data ^ op_b;
      mips_pkg::SLT: begin
        // two's complement compare
        result = {31'd0, $signed(rs_data) < $signed(op_b)};
      end
      mips_pkg::SLL: result = rt_data << shamt; // shifts ignore rs
      mips_pkg::SRL: result = rt_data >> shamt; // logical, zero fill
      mips_pkg::LUI: result = {imm, 16'h0000};
      default:       result = rs_data + op_b;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
  parameter mips_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            exec,
  decode_if.datapath           dec,
  input  wire mips_pkg::word_t instr,
  input  wire mips_pkg::word_t rs_data,
  input  wire mips_pkg::word_t rt_data,
  output mips_pkg::word_t      pc,
  output mips_pkg::word_t      pc_plus8 // return address, also untaken target
);

  mips_pkg::word_t pc_plus4;
  mips_pkg::word_t branch_target;
  mips_pkg::word_t jump_target;
  mips_pkg::word_t next_target;  // where to go after the delay slot
  mips_pkg::word_t delay_target; // saved while the delay slot runs
  logic            delay;        // previous instruction was a branch or jump
  logic            taken;

  assign pc_plus4 = pc + 32'd4;
  assign pc_plus8 = pc + 32'd8;

  // offset is relative to the delay slot address
  assign branch_target = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00}; // same 256MB region

  assign taken = dec.branch & ((rs_data == rt_data) ^ dec.branch_ne);

  always_comb begin
    if (dec.jump_reg)  next_target = rs_data;
    else if (dec.jump) next_target = jump_target;
    else if (taken)    next_target = branch_target;
    else               next_target = pc_plus8; // untaken, skip past the slot
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= reset_pc;
      delay <= 1'b0;
    end else if (exec) begin
      pc    <= delay ? delay_target : pc_plus4;
      delay <= dec.branch | dec.jump | dec.jump_reg; // next one is a delay slot
    end
  end

  // pc for the instruction that follows the delay slot
  always_ff @(posedge clk) begin
    if (exec) delay_target <= next_target;
  end

endmodule

`default_nettype wire

// File: verilog/mips_cpu_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module mips_cpu_bus (
  input  wire logic         clk,
  input  wire logic         reset,
  output logic              active,
  output logic [31:0]       register_v0,

  // avalon-mm master
  output logic [31:0]       address,
  output logic              write,
  output logic              read,
  input  wire logic         waitrequest,
  output logic [31:0]       writedata,
  output logic [3:0]        byteenable,
  input  wire logic [31:0]  readdata
);

  mips_pkg::cpu_state_t state;
  mips_pkg::word_t      instr;
  mips_pkg::word_t      load_data;
  mips_pkg::word_t      pc;
  mips_pkg::word_t      pc_plus8;
  mips_pkg::word_t      rs_data;
  mips_pkg::word_t      rt_data;
  mips_pkg::word_t      alu_result;
  mips_pkg::word_t      wb_data;
  logic                 data_phase;
  logic                 exec;

  decode_if dec ();

  assign exec = (state == mips_pkg::EXEC); // commit cycle for pc and registers

  // pc during the instruction read, word aligned alu address in mem
  assign address    = data_phase ? {alu_result[31:2], 2'b00} : pc;
  assign writedata  = rt_data;
  assign byteenable = 4'b1111; // word accesses only

  // load wins over link, link over the alu
  always_comb begin
    if (dec.mem_read)  wb_data = load_data;
    else if (dec.link) wb_data = pc_plus8;
    else               wb_data = alu_result;
  end

  cpu_sequencer i_cpu_sequencer (
    .clk         (clk),
    .reset       (reset),
    .waitrequest (waitrequest),
    .readdata    (readdata),
    .pc          (pc),
    .dec         (dec.datapath),
    .state       (state),
    .instr       (instr),
    .load_data   (load_data),
    .read        (read),
    .write       (write),
    .data_phase  (data_phase),
    .active      (active)
  );

  instr_decoder i_instr_decoder (
    .instr (instr),
    .dec   (dec.decoder)
  );

  register_file i_register_file (
    .clk         (clk),
    .reset       (reset),
    .exec        (exec),
    .rs_idx      (instr[25:21]),
    .rt_idx      (instr[20:16]),
    .dest_idx    (dec.dest_reg),
    .write_en    (dec.reg_write),
    .write_data  (wb_data),
    .rs_data     (rs_data),
    .rt_data     (rt_data),
    .register_v0 (register_v0)
  );

  alu i_alu (
    .dec     (dec.datapath),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .imm     (instr[15:0]),
    .shamt   (instr[10:6]),
    .result  (alu_result)
  );

  pc_unit #(
    .reset_pc (`MIPS_RESET_VECTOR)
  ) i_pc_unit (
    .clk      (clk),
    .reset    (reset),
    .exec     (exec),
    .dec      (dec.datapath),
    .instr    (instr),
    .rs_data  (rs_data),
    .rt_data  (rt_data),
    .pc       (pc),
    .pc_plus8 (pc_plus8)
  );

endmodule

`default_nettype wire

// File: dv/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// instruction-level model of the same program, data accesses go to ref_ram
function automatic logic [31:0] ref_read(input logic [31:0] a);
  if (in_ram(a)) return ref_ram[a[7:2]];
  if (in_rom(a)) return rom[a[7:2]];
  return '0; // word 0 and unmapped space read as nop
endfunction

function automatic logic [31:0] run_reference(output int steps);
  logic [31:0] regs [32];
  logic [31:0] pc;
  logic [31:0] pc4;
  logic [31:0] target;     // pending delay-slot target
  logic [31:0] new_target;
  logic [31:0] ins, rs, rt, imm_s, imm_z, res;
  logic        delay, redirect, wr;
  logic [4:0]  dst;
  for (int i = 0; i < 32; i++) regs[i] = '0;
  pc = `MIPS_RESET_VECTOR;
  target = '0;
  delay = 1'b0;
  steps = 0;
  ref_stores = 0;
  while (steps < 1000) begin
    ins = ref_read(pc);
    pc4 = pc + 32'd4;
    rs = regs[ins[25:21]];
    rt = regs[ins[20:16]];
    imm_s = {{16{ins[15]}}, ins[15:0]};
    imm_z = {16'h0000, ins[15:0]};
    dst = ins[20:16]; // i-type writes rt
    wr = 1'b1;
    res = '0;
    redirect = 1'b0;
    new_target = pc + 32'd8; // untaken branch skips the slot
    case (ins[31:26])
      `MIPS_OP_RTYPE: begin
        dst = ins[15:11];
        case (ins[5:0])
          `MIPS_FN_SLL:  res = rt << ins[10:6];
          `MIPS_FN_SRL:  res = rt >> ins[10:6];
          `MIPS_FN_ADDU: res = rs + rt;
          `MIPS_FN_SUBU: res = rs - rt;
          `MIPS_FN_AND:  res = rs & rt;
          `MIPS_FN_OR:   res = rs | rt;
          `MIPS_FN_XOR:  res = rs ^ rt;
          `MIPS_FN_SLT:  res = {31'd0, $signed(rs) < $signed(rt)};
          `MIPS_FN_JR: begin
            wr = 1'b0;
            redirect = 1'b1;
            new_target = rs;
          end
          default: wr = 1'b0;
        endcase
      end
      `MIPS_OP_J, `MIPS_OP_JAL: begin
        wr = (ins[31:26] == `MIPS_OP_JAL); // only jal links
        dst = `MIPS_REG_RA;
        res = pc + 32'd8;
        redirect = 1'b1;
        new_target = {pc4[31:28], ins[25:0], 2'b00};
      end
      `MIPS_OP_BEQ, `MIPS_OP_BNE: begin
        wr = 1'b0;
        redirect = 1'b1;
        if ((rs == rt) != (ins[31:26] == `MIPS_OP_BNE)) new_target = pc4 + {imm_s[29:0], 2'b00};
      end
      `MIPS_OP_ADDIU: res = rs + imm_s;
      `MIPS_OP_SLTI:  res = {31'd0, $signed(rs) < $signed(imm_s)};
      `MIPS_OP_ANDI:  res = rs & imm_z;
      `MIPS_OP_ORI:   res = rs | imm_z;
      `MIPS_OP_XORI:  res = rs ^ imm_z;
      `MIPS_OP_LUI:   res = {ins[15:0], 16'h0000};
      `MIPS_OP_LW:    res = ref_read(rs + imm_s); // low address bits ignored
      `MIPS_OP_SW: begin
        wr = 1'b0;
        res = rs + imm_s;
        if (in_ram(res)) ref_ram[res[7:2]] = rt;
        ref_stores++;
      end
      default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0) regs[dst] = res;
    steps++;
    if (pc == '0) return regs[`MIPS_REG_V0]; // halts after running address 0
    pc = delay ? target : pc4;
    delay = redirect;
    if (redirect) target = new_target;
  end
  failures++;
  $display("reference model did not reach address 0 within 1000 instructions");
  return regs[`MIPS_REG_V0];
endfunction

`endif

// File: dv/tb_mips_cpu_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module tb_mips_cpu_bus;

  localparam logic [31:0] ram_base = 32'h0000_1000; // 64-word data region
  localparam int max_stall = 4;  // longest run of waitrequest cycles
  localparam int num_progs = 4;

  logic        clk, reset, active, read, write, waitrequest;
  logic [31:0] register_v0, address, writedata, readdata;
  logic [3:0]  byteenable;

  logic [31:0] rom [64];     // reset-vector region, holds the program
  logic [31:0] ram [64];     // data region seen by the DUT
  logic [31:0] ref_ram [64]; // data region of the reference model
  logic [31:0] exp_v0;
  logic [31:0] base_v0 [num_progs];  // stall-free results per program
  logic [31:0] base_sum [num_progs];
  int          seed, stall_pct, stall_run, fetches, wr_count, ref_stores;
  int          prog_len, exp_steps, cur_prog, cur_pct, mismatches, failures;
  bit          first_seen, compare_req;
  longint      watchdog_ns;

  function automatic bit in_ram(input logic [31:0] a);
    return a[31:8] == ram_base[31:8];
  endfunction

  function automatic bit in_rom(input logic [31:0] a);
    return a[31:8] == 24'hbfc000;
  endfunction

  `include "tb_ref_model.svh"

  mips_cpu_bus i_mips_cpu_bus (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .register_v0 (register_v0),
    .address     (address),
    .write       (write),
    .read        (read),
    .waitrequest (waitrequest),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .readdata    (readdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] fill_pattern(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  // instruction encoders, argument order follows assembly syntax
  function automatic logic [31:0] alu_rr(input logic [5:0] fn, input int rd, rs, rt);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic logic [31:0] shift_ri(input logic [5:0] fn, input int rd, rt, sa);
    return {6'h00, 5'd0, rt[4:0], rd[4:0], sa[4:0], fn};
  endfunction

  function automatic logic [31:0] imm_op(input logic [5:0] op, input int rt, rs,
                                         input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction

  function automatic logic [31:0] jump_to(input logic [5:0] op, input int idx);
    logic [31:0] a;
    a = `MIPS_RESET_VECTOR + 4 * idx;
    return {op, a[27:2]};
  endfunction

  task automatic emit(input logic [31:0] w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  task automatic build_program(input int prog);
    for (int i = 0; i < 64; i++) rom[i] = fill_pattern(`MIPS_RESET_VECTOR + 4 * i);
    prog_len = 0;
    case (prog)
      0: begin // every alu operation folded into v0
        emit(imm_op(`MIPS_OP_ADDIU, 8, 0, 16'h1234));
        emit(imm_op(`MIPS_OP_ADDIU, 9, 0, 16'hfffb)); // -5
        emit(imm_op(`MIPS_OP_LUI, 10, 0, 16'h8765));
        emit(imm_op(`MIPS_OP_ORI, 10, 10, 16'h4321));
        emit(alu_rr(`MIPS_FN_SUBU, 11, 9, 8));
        emit(alu_rr(`MIPS_FN_AND, 12, 10, 11));
        emit(alu_rr(`MIPS_FN_OR, 13, 12, 8));
        emit(alu_rr(`MIPS_FN_XOR, 2, 13, 9));
        emit(alu_rr(`MIPS_FN_SLT, 14, 9, 8));  // signed, negative rs
        emit(alu_rr(`MIPS_FN_SLT, 15, 8, 10)); // signed, negative rt
        emit(alu_rr(`MIPS_FN_ADDU, 2, 2, 14));
        emit(alu_rr(`MIPS_FN_ADDU, 2, 2, 15));
        emit(shift_ri(`MIPS_FN_SLL, 16, 10, 4));
        emit(shift_ri(`MIPS_FN_SRL, 17, 10, 7)); // zero fill from the top
        emit(alu_rr(`MIPS_FN_XOR, 2, 2, 16));
        emit(alu_rr(`MIPS_FN_SUBU, 2, 2, 17));
        emit(imm_op(`MIPS_OP_SLTI, 18, 9, 16'hfffd));
        emit(imm_op(`MIPS_OP_ANDI, 19, 10, 16'hf0f0));
        emit(imm_op(`MIPS_OP_XORI, 20, 9, 16'h8001)); // zero extended
        emit(alu_rr(`MIPS_FN_ADDU, 2, 2, 18));
        emit(alu_rr(`MIPS_FN_XOR, 2, 2, 19));
        emit(alu_rr(`MIPS_FN_ADDU, 2, 2, 20));
      end
      1: begin // stores and loads in the data region
        emit(imm_op(`MIPS_OP_ADDIU, 8, 0, ram_base[15:0]));
        emit(imm_op(`MIPS_OP_LUI, 9, 0, 16'h1357));
        emit(imm_op(`MIPS_OP_ORI, 9, 9, 16'h9bdf));
        emit(imm_op(`MIPS_OP_SW, 9, 8, 16'h0008));
        emit(imm_op(`MIPS_OP_LW, 10, 8, 16'h0008));
        emit(imm_op(`MIPS_OP_LW, 11, 8, 16'h000c)); // untouched fill word
        emit(alu_rr(`MIPS_FN_ADDU, 2, 10, 11));
        emit(imm_op(`MIPS_OP_SW, 2, 8, 16'h003c));
        emit(imm_op(`MIPS_OP_SW, 11, 8, 16'h0013)); // unaligned offset, lands on word 4
        emit(imm_op(`MIPS_OP_LW, 12, 8, 16'h0010));
        emit(alu_rr(`MIPS_FN_XOR, 2, 2, 12));
      end
      2: begin // taken and untaken branches, each slot runs
        emit(imm_op(`MIPS_OP_ADDIU, 8, 0, 16'h0005));
        emit(imm_op(`MIPS_OP_ADDIU, 9, 0, 16'h0005));
        emit(imm_op(`MIPS_OP_BEQ, 9, 8, 16'h0002)); // taken
        emit(imm_op(`MIPS_OP_ADDIU, 2, 0, 16'h0001));
        emit(imm_op(`MIPS_OP_ADDIU, 2, 2, 16'h0100)); // skipped
        emit(imm_op(`MIPS_OP_ADDIU, 2, 2, 16'h0010));
        emit(imm_op(`MIPS_OP_BNE, 9, 8, 16'h0002)); // untaken
        emit(imm_op(`MIPS_OP_ADDIU, 2, 2, 16'h0002));
        emit(imm_op(`MIPS_OP_ADDIU, 2, 2, 16'h0200));
        emit(imm_op(`MIPS_OP_BEQ, 0, 8, 16'h0002)); // untaken
        emit(imm_op(`MIPS_OP_ADDIU, 2, 2, 16'h0004));
        emit(imm_op(`MIPS_OP_BNE, 0, 8, 16'h0002)); // taken
        emit(imm_op(`MIPS_OP_ADDIU, 2, 2, 16'h0008));
        emit(imm_op(`MIPS_OP_ADDIU, 2, 2, 16'h0400)); // skipped
        emit(imm_op(`MIPS_OP_ADDIU, 2, 2, 16'h0020));
      end
      default: begin // jal into a subroutine, jr back, j to the exit
        emit(jump_to(`MIPS_OP_JAL, 5));
        emit(imm_op(`MIPS_OP_ADDIU, 2, 0, 16'h0003));
        emit(alu_rr(`MIPS_FN_ADDU, 2, 2, 3)); // return point, pc+8 of the jal
        emit(jump_to(`MIPS_OP_J, 8));
        emit(imm_op(`MIPS_OP_ADDIU, 2, 2, 16'h0040));
        emit(alu_rr(`MIPS_FN_ADDU, 3, 31, 0));
        emit(alu_rr(`MIPS_FN_JR, 0, 31, 0));
        emit(alu_rr(`MIPS_FN_OR, 2, 31, 0)); // link value moved to v0 in the slot
      end
    endcase
    emit(alu_rr(`MIPS_FN_JR, 0, 0, 0)); // common exit to address 0
    emit(32'h0000_0000);
  endtask

  task automatic fill_memories();
    for (int i = 0; i < 64; i++) begin
      ram[i] = fill_pattern(ram_base + 4 * i);
      ref_ram[i] = ram[i];
    end
  endtask

  // avalon slave, strobes and address are stable around the falling edge
  always @(negedge clk) begin
    waitrequest = 1'b0;
    if (!reset && (read || write)) begin
      if (active !== 1'b1) begin
        failures++;
        $display("bus strobe to %h at %0t after active fell", address, $time);
      end
      if (!first_seen) begin
        first_seen = 1'b1;
        if (address !== `MIPS_RESET_VECTOR || read !== 1'b1 || write !== 1'b0) begin
          mismatches++;
          $display("MISMATCH at %0t: first strobe read=%b write=%b address %h, expected read at %h",
                   $time, read, write, address, `MIPS_RESET_VECTOR);
        end
      end
      if (stall_run < max_stall && $unsigned($random(seed)) % 100 < stall_pct) begin
        waitrequest = 1'b1;
        stall_run++;
      end else if (read) begin
        stall_run = 0;
        if (in_ram(address)) readdata = ram[address[7:2]];
        else if (in_rom(address) || address == '0) begin
          readdata = in_rom(address) ? rom[address[7:2]] : '0; // word 0 is a nop
          fetches++;
        end else begin
          failures++;
          $display("read from unmapped address %h at %0t", address, $time);
        end
      end else begin
        stall_run = 0;
        wr_count++;
        if (byteenable !== 4'b1111 || address[1:0] !== 2'b00) begin
          mismatches++;
          $display("MISMATCH at %0t: write to %h with byteenable %b", $time, address, byteenable);
        end
        if (in_ram(address)) ram[address[7:2]] = writedata;
        else begin
          failures++;
          $display("write outside the data region at %h", address);
        end
      end
    end
  end

  always @(posedge compare_req) begin
    logic [31:0] sum;
    sum = '0;
    if (register_v0 !== exp_v0) begin
      mismatches++;
      $display("MISMATCH at %0t: program %0d stall %0d%%: v0 %h, expected %h",
               $time, cur_prog, cur_pct, register_v0, exp_v0);
    end
    for (int i = 0; i < 64; i++) begin
      sum = {sum[30:0], sum[31]} ^ ram[i];
      if (ram[i] !== ref_ram[i]) begin
        mismatches++;
        $display("MISMATCH at %0t: program %0d data word %0d is %h, expected %h",
                 $time, cur_prog, i, ram[i], ref_ram[i]);
      end
    end
    if (fetches != exp_steps || wr_count != ref_stores) begin
      mismatches++;
      $display("MISMATCH at %0t: program %0d ran %0d fetches %0d writes, expected %0d and %0d",
               $time, cur_prog, fetches, wr_count, exp_steps, ref_stores);
    end
    if (cur_pct == 0) begin
      base_v0[cur_prog] = register_v0;
      base_sum[cur_prog] = sum;
    end else if (register_v0 !== base_v0[cur_prog] || sum !== base_sum[cur_prog]) begin
      mismatches++;
      $display("MISMATCH at %0t: program %0d differs from its stall-free run", $time, cur_prog);
    end
    compare_req = 1'b0;
  end

  task automatic run_program(input int prog, input int pct);
    build_program(prog);
    fill_memories();
    exp_v0 = run_reference(exp_steps);
    cur_prog = prog;
    cur_pct = pct;
    stall_pct = pct;
    stall_run = 0;
    first_seen = 1'b0;
    fetches = 0;
    wr_count = 0;
    @(negedge clk);
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    if (active !== 1'b1) begin
      failures++;
      $display("active is not high after reset for program %0d", prog);
    end
    while (active === 1'b1) @(negedge clk);
    repeat (20) @(negedge clk); // bus must stay quiet once halted
    compare_req = 1'b1;
    wait (!compare_req);
  endtask

  initial begin
    int total_steps;
    int steps;
    reset = 1'b1;
    waitrequest = 1'b0;
    readdata = '0;
    seed = 32'hf036_875a;
    mismatches = 0;
    failures = 0;
    total_steps = 0;
    for (int p = 0; p < num_progs; p++) begin
      build_program(p);
      fill_memories();
      void'(run_reference(steps));
      total_steps += steps;
    end
    // fetch, two stalled accesses and exec per instruction, two stall modes
    watchdog_ns = 10 * (2 * total_steps * (2 * max_stall + 4) + 2 * num_progs * 40);
    for (int mode = 0; mode < 2; mode++) begin
      for (int p = 0; p < num_progs; p++) run_program(p, mode == 0 ? 0 : 75);
    end
    $display("%0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (watchdog_ns != 0);
    #(watchdog_ns);
    failures++;
    $display("timeout: the DUT did not halt within %0d ns", watchdog_ns);
    $display("%0d mismatches, %0d other errors", mismatches, failures);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: mips_cpu_bus.f
+incdir+verilog
+incdir+dv
verilog/mips_pkg.sv
verilog/decode_if.sv
verilog/cpu_sequencer.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/alu.sv
verilog/pc_unit.sv
verilog/mips_cpu_bus.sv
dv/tb_mips_cpu_bus.sv

// File: Bender.yml
package:
  name: mips_cpu_bus

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mips_pkg.sv
      - verilog/decode_if.sv
      - verilog/cpu_sequencer.sv
      - verilog/instr_decoder.sv
      - verilog/register_file.sv
      - verilog/alu.sv
      - verilog/pc_unit.sv
      - verilog/mips_cpu_bus.sv
  - target: simulation
    include_dirs:
      - verilog
      - dv
    files:
      - dv/tb_mips_cpu_bus.sv
